/* design/dma_defs.svh */
// ----------------------------------------------------------
// global sizes for the DMA frontend
// addresses and byte counts share one width; ids are 32 bits
// queue depths are not checked against the burst engine
// ----------------------------------------------------------
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// address, byte count, stride and repetition width
`define DMA_ADDR_WIDTH 32

// transfer id width, also the status response width
`define DMA_ID_WIDTH 32

// 2D jobs waiting behind the one being split
`define DMA_JOB_DEPTH 4

// bursts in flight at the engine
`define DMA_TRACK_DEPTH 8

// tag width of the accelerator bus
`define DMA_TAG_WIDTH 5

`endif

/* design/dma_cmd_pkg.sv */
// ----------------------------------------------------------
// command side types of the accelerator bus
// opcodes 6 and 7 are unused and answered with an error
// ----------------------------------------------------------
`include "dma_defs.svh"

package dma_cmd_pkg;

    // compact opcode set, stands in for the RISC-V encodings
    typedef enum logic [2:0] {
        OP_SRC  = 3'd0,
        OP_DST  = 3'd1,
        OP_STR  = 3'd2,
        OP_REP  = 3'd3,
        OP_CPY  = 3'd4,
        OP_STAT = 3'd5
    } dma_op_e;

    // request strobed by the core
    // OP_CPY: arga = bytes, argb[1] = 2D
    // OP_STAT: argb[1:0] = status index
    typedef struct packed {
        dma_op_e                    op;
        logic [`DMA_TAG_WIDTH-1:0]  tag;
        logic [`DMA_ADDR_WIDTH-1:0] arga;
        logic [`DMA_ADDR_WIDTH-1:0] argb;
    } acc_req_t;

    // response back to the core
    typedef struct packed {
        logic [`DMA_TAG_WIDTH-1:0] tag;
        logic [31:0]               data;
        logic                      error;
    } acc_rsp_t;

endpackage

/* design/dma_xfer_pkg.sv */
// ----------------------------------------------------------
// transfer side types between decoder, splitter and tracker
// no cache or burst-type attributes, all bursts are INCR
// ----------------------------------------------------------
`include "dma_defs.svh"

package dma_xfer_pkg;

    // one 2D job as handed over by the decoder
    typedef struct packed {
        logic [`DMA_ID_WIDTH-1:0]   id;
        logic [`DMA_ADDR_WIDTH-1:0] src;
        logic [`DMA_ADDR_WIDTH-1:0] dst;
        logic [`DMA_ADDR_WIDTH-1:0] num_bytes;
        logic [`DMA_ADDR_WIDTH-1:0] stride_src;
        logic [`DMA_ADDR_WIDTH-1:0] stride_dst;
        logic [`DMA_ADDR_WIDTH-1:0] num_repetitions;
        logic                       is_twod;
    } twod_req_t;

    // one 1D burst toward the engine
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] src;
        logic [`DMA_ADDR_WIDTH-1:0] dst;
        logic [`DMA_ADDR_WIDTH-1:0] num_bytes;
        // final burst of its job
        logic                       last;
    } burst_req_t;

endpackage

/* design/dma_fifo.sv */
// ----------------------------------------------------------
// small synchronous FIFO, head visible without a pop
// push while full and pop while empty are dropped
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned depth     = `DMA_JOB_DEPTH
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int unsigned ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned count_w = $clog2(depth + 1);

    payload_t           mem_q [depth];
    logic [ptr_w-1:0]   wr_ptr_q;
    logic [ptr_w-1:0]   rd_ptr_q;
    logic [count_w-1:0] count_q;
    logic               do_push;
    logic               do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == count_w'(depth));
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

/* design/dma_cmd_decoder.sv */
// ----------------------------------------------------------
// command decoder with shadow descriptor and id counters
// copy and status answer one cycle later
// configuration ops give no answer
// a copy into a full job queue is refused with an error
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_cmd_decoder
    import dma_cmd_pkg::*;
    import dma_xfer_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      acc_req_valid_i,
    input  acc_req_t  acc_req_i,
    output logic      acc_rsp_valid_o,
    output acc_rsp_t  acc_rsp_o,
    output logic      job_valid_o,
    output twod_req_t job_o,
    input  logic      job_full_i,
    input  logic      xfer_done_i,
    output logic      busy_o
);

    twod_req_t                shadow_q;
    twod_req_t                shadow_d;
    logic [`DMA_ID_WIDTH-1:0] next_id_q;
    logic [`DMA_ID_WIDTH-1:0] completed_id_q;
    logic                     rsp_valid_d;
    acc_rsp_t                 rsp_d;

    // in flight as long as some id has not come back
    assign busy_o = (next_id_q != completed_id_q);

    // ----------------------------------------------------------
    // decode
    // ----------------------------------------------------------
    always_comb begin
        shadow_d        = shadow_q;
        job_valid_o     = 1'b0;
        job_o           = shadow_q;
        job_o.id        = next_id_q;
        job_o.num_bytes = acc_req_i.arga;
        job_o.is_twod   = acc_req_i.argb[1];
        rsp_valid_d     = 1'b0;
        rsp_d           = '0;
        rsp_d.tag       = acc_req_i.tag;
        rsp_d.error     = 1'b1;

        if (acc_req_valid_i) begin
            case (acc_req_i.op)
                OP_SRC: shadow_d.src = acc_req_i.arga;
                OP_DST: shadow_d.dst = acc_req_i.arga;
                OP_STR: begin
                    shadow_d.stride_src = acc_req_i.arga;
                    shadow_d.stride_dst = acc_req_i.argb;
                end
                OP_REP: shadow_d.num_repetitions = acc_req_i.arga;
                OP_CPY: begin
                    rsp_valid_d = 1'b1;
                    // refused copy keeps data zero and the error bit
                    if (!job_full_i) begin
                        job_valid_o = 1'b1;
                        rsp_d.data  = next_id_q;
                        rsp_d.error = 1'b0;
                    end
                end
                OP_STAT: begin
                    rsp_valid_d = 1'b1;
                    rsp_d.error = 1'b0;
                    case (acc_req_i.argb[1:0])
                        2'd0:    rsp_d.data = completed_id_q;
                        2'd1:    rsp_d.data = next_id_q;
                        2'd2:    rsp_d.data = {{31{1'b0}}, busy_o};
                        default: rsp_d.data = {{31{1'b0}}, job_full_i};
                    endcase
                end
                // unknown opcode answered with an error and the strobed tag
                default: rsp_valid_d = 1'b1;
            endcase
        end
    end

    // ----------------------------------------------------------
    // state
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            shadow_q        <= '0;
            next_id_q       <= '0;
            completed_id_q  <= '0;
            acc_rsp_valid_o <= 1'b0;
        end else begin
            shadow_q        <= shadow_d;
            acc_rsp_valid_o <= rsp_valid_d;
            if (job_valid_o) begin
                next_id_q <= next_id_q + 1'b1;
            end
            if (xfer_done_i) begin
                completed_id_q <= completed_id_q + 1'b1;
            end
        end
    end

    // response payload
    always_ff @(posedge clk_i) begin
        acc_rsp_o <= rsp_d;
    end

endmodule

/* design/dma_twod_splitter.sv */
// ----------------------------------------------------------
// 2D splitter, one burst per issue cycle
// addresses advance by adding the strides, no multiplier
// num_repetitions of 0 or 1 behaves as a 1D copy
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_twod_splitter
    import dma_xfer_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       job_valid_i,
    input  twod_req_t  job_i,
    output logic       job_full_o,
    output logic       burst_valid_o,
    output burst_req_t burst_o,
    input  logic       track_full_i
);

    twod_req_t                  head_job;
    logic                       job_empty;
    logic                       job_pop;
    twod_req_t                  cur_q;
    logic                       cur_valid_q;
    logic [`DMA_ADDR_WIDTH-1:0] rem_q;
    logic                       cur_last;
    logic                       issue;

    // ----------------------------------------------------------
    // job queue
    // ----------------------------------------------------------
    dma_fifo #(
        .payload_t ( twod_req_t     ),
        .depth     ( `DMA_JOB_DEPTH )
    ) i_job_fifo (
        .clk_i   ( clk_i       ),
        .rst_n_i ( rst_n_i     ),
        .push_i  ( job_valid_i ),
        .data_i  ( job_i       ),
        .pop_i   ( job_pop     ),
        .data_o  ( head_job    ),
        .empty_o ( job_empty   ),
        .full_o  ( job_full_o  )
    );

    assign cur_last = (rem_q == `DMA_ADDR_WIDTH'(1));
    assign issue    = cur_valid_q & ~track_full_i;
    // load when idle or right after the last burst leaves
    assign job_pop  = ~job_empty & (~cur_valid_q | (issue & cur_last));

    // ----------------------------------------------------------
    // current job
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cur_valid_q <= 1'b0;
            rem_q       <= '0;
        end else if (job_pop) begin
            cur_valid_q <= 1'b1;
            if (head_job.is_twod && (head_job.num_repetitions > `DMA_ADDR_WIDTH'(1))) begin
                rem_q <= head_job.num_repetitions;
            end else begin
                rem_q <= `DMA_ADDR_WIDTH'(1);
            end
        end else if (issue) begin
            if (cur_last) begin
                cur_valid_q <= 1'b0;
            end else begin
                rem_q <= rem_q - 1'b1;
            end
        end
    end

    // running addresses
    always_ff @(posedge clk_i) begin
        if (job_pop) begin
            cur_q <= head_job;
        end else if (issue) begin
            cur_q.src <= cur_q.src + cur_q.stride_src;
            cur_q.dst <= cur_q.dst + cur_q.stride_dst;
        end
    end

    assign burst_valid_o     = cur_valid_q;
    assign burst_o.src       = cur_q.src;
    assign burst_o.dst       = cur_q.dst;
    assign burst_o.num_bytes = cur_q.num_bytes;
    assign burst_o.last      = cur_last;

endmodule

/* design/dma_burst_tracker.sv */
// ----------------------------------------------------------
// registers issued bursts toward the engine
// completions must arrive in issue order, one per burst
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_burst_tracker
    import dma_xfer_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       burst_valid_i,
    input  burst_req_t burst_i,
    output logic       track_full_o,
    output logic       burst_valid_o,
    output burst_req_t burst_o,
    input  logic       burst_done_i,
    output logic       xfer_done_o
);

    logic flag_head;
    logic flag_empty;
    logic issue;

    assign issue = burst_valid_i & ~track_full_o;

    // one last flag per outstanding burst
    dma_fifo #(
        .payload_t ( logic            ),
        .depth     ( `DMA_TRACK_DEPTH )
    ) i_last_fifo (
        .clk_i   ( clk_i        ),
        .rst_n_i ( rst_n_i      ),
        .push_i  ( issue        ),
        .data_i  ( burst_i.last ),
        .pop_i   ( burst_done_i ),
        .data_o  ( flag_head    ),
        .empty_o ( flag_empty   ),
        .full_o  ( track_full_o )
    );

    assign xfer_done_o = burst_done_i & ~flag_empty & flag_head;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            burst_valid_o <= 1'b0;
        end else begin
            burst_valid_o <= issue;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            burst_o <= burst_i;
        end
    end

endmodule

/* design/dma_tc_top.sv */
// ----------------------------------------------------------
// tightly-coupled DMA frontend
// all strobes are single cycle without back-pressure
// the engine answers every burst once, in order
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_tc_top
    import dma_cmd_pkg::*;
    import dma_xfer_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       acc_req_valid_i,
    input  acc_req_t   acc_req_i,
    output logic       acc_rsp_valid_o,
    output acc_rsp_t   acc_rsp_o,
    output logic       burst_valid_o,
    output burst_req_t burst_o,
    input  logic       burst_done_i,
    output logic       busy_o
);

    logic       job_valid;
    twod_req_t  job;
    logic       job_full;
    logic       split_valid;
    burst_req_t split_burst;
    logic       track_full;
    logic       xfer_done;

    // input side
    dma_cmd_decoder i_cmd_decoder (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .acc_req_valid_i ( acc_req_valid_i ),
        .acc_req_i       ( acc_req_i       ),
        .acc_rsp_valid_o ( acc_rsp_valid_o ),
        .acc_rsp_o       ( acc_rsp_o       ),
        .job_valid_o     ( job_valid       ),
        .job_o           ( job             ),
        .job_full_i      ( job_full        ),
        .xfer_done_i     ( xfer_done       ),
        .busy_o          ( busy_o          )
    );

    // 2D expansion
    dma_twod_splitter i_twod_splitter (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .job_valid_i   ( job_valid   ),
        .job_i         ( job         ),
        .job_full_o    ( job_full    ),
        .burst_valid_o ( split_valid ),
        .burst_o       ( split_burst ),
        .track_full_i  ( track_full  )
    );

    // output side
    dma_burst_tracker i_burst_tracker (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .burst_valid_i ( split_valid   ),
        .burst_i       ( split_burst   ),
        .track_full_o  ( track_full    ),
        .burst_valid_o ( burst_valid_o ),
        .burst_o       ( burst_o       ),
        .burst_done_i  ( burst_done_i  ),
        .xfer_done_o   ( xfer_done     )
    );

endmodule

/* tests/dma_tc_tb.sv */
// ----------------------------------------------------------
// testbench for the DMA frontend with a burst engine model
// engine answers each burst in order after 1 to 6 cycles
// status reads that follow a drain wait for the model to idle
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_tc_tb
    import dma_cmd_pkg::*;
    import dma_xfer_pkg::*;
();

    // one command, its expected answer and the gap after it
    typedef struct packed {
        acc_req_t   req;
        logic       expect_rsp;
        acc_rsp_t   rsp;
        logic [7:0] idle;
        logic       drain;
    } step_t;

    logic       clk_i;
    logic       rst_n_i;
    logic       acc_req_valid_i;
    acc_req_t   acc_req_i;
    logic       acc_rsp_valid_o;
    acc_rsp_t   acc_rsp_o;
    logic       burst_valid_o;
    burst_req_t burst_o;
    logic       burst_done_i;
    logic       busy_o;

    step_t       steps[$];
    burst_req_t  exp_bursts[$];
    int unsigned done_ready[$];
    logic        done_last[$];
    integer      seed = 54672;
    int unsigned cycle = 0;
    int unsigned last_ready = 0;
    int unsigned exp_next_id = 0;
    int unsigned exp_completed = 0;
    logic        done_last_pending = 1'b0;
    logic        rsp_allowed = 1'b0;

    // reference copy of the shadow descriptor
    logic [`DMA_ADDR_WIDTH-1:0] m_src = '0;
    logic [`DMA_ADDR_WIDTH-1:0] m_dst = '0;
    logic [`DMA_ADDR_WIDTH-1:0] m_str_src = '0;
    logic [`DMA_ADDR_WIDTH-1:0] m_str_dst = '0;
    logic [`DMA_ADDR_WIDTH-1:0] m_reps = '0;

    dma_tc_top dma_tc_top_inst (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .acc_req_valid_i ( acc_req_valid_i ),
        .acc_req_i       ( acc_req_i       ),
        .acc_rsp_valid_o ( acc_rsp_valid_o ),
        .acc_rsp_o       ( acc_rsp_o       ),
        .burst_valid_o   ( burst_valid_o   ),
        .burst_o         ( burst_o         ),
        .burst_done_i    ( burst_done_i    ),
        .busy_o          ( busy_o          )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------
    // failure handling and compare tasks
    // ----------------------------------------------------------
    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_rsp(input acc_rsp_t got, input acc_rsp_t exp);
        if (got !== exp) begin
            $display("Error: %0t response tag %0d data %h error %b, expected tag %0d data %h error %b",
                     $time, got.tag, got.data, got.error, exp.tag, exp.data, exp.error);
            abort_run();
        end
    endtask

    task automatic check_burst(input burst_req_t got, input burst_req_t exp);
        if (got !== exp) begin
            $display("Error: %0t burst src %h dst %h bytes %0d last %b, expected %h %h %0d %b",
                     $time, got.src, got.dst, got.num_bytes, got.last,
                     exp.src, exp.dst, exp.num_bytes, exp.last);
            abort_run();
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %0t busy_o is %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    function automatic bit model_idle();
        return (exp_bursts.size() == 0) && (done_ready.size() == 0) && !burst_done_i &&
               !done_last_pending && (exp_next_id == exp_completed);
    endfunction

    // splitting rule for an accepted copy
    task automatic push_bursts(input logic [`DMA_ADDR_WIDTH-1:0] bytes, input logic twod);
        int unsigned n;
        int unsigned k;
        burst_req_t  b;
        n = (twod && (m_reps > 1)) ? m_reps : 1;
        for (k = 0; k < n; k++) begin
            b.src       = m_src + k * m_str_src;
            b.dst       = m_dst + k * m_str_dst;
            b.num_bytes = bytes;
            b.last      = (k == n - 1);
            exp_bursts.push_back(b);
        end
    endtask

    task automatic add_step(input logic [2:0] op, input int tag,
                            input logic [31:0] arga, input logic [31:0] argb,
                            input logic expect_rsp, input logic [31:0] data,
                            input logic error, input int idle, input logic drain);
        step_t s;
        s.req.op     = dma_op_e'(op);
        s.req.tag    = tag[`DMA_TAG_WIDTH-1:0];
        s.req.arga   = arga;
        s.req.argb   = argb;
        s.expect_rsp = expect_rsp;
        s.rsp.tag    = tag[`DMA_TAG_WIDTH-1:0];
        s.rsp.data   = data;
        s.rsp.error  = error;
        s.idle       = idle[7:0];
        s.drain      = drain;
        steps.push_back(s);
    endtask

    // waits on the model, the watchdog bounds it
    task automatic wait_idle();
        do begin
            @(negedge clk_i);
        end while (!model_idle());
        @(posedge clk_i);
        #2;
    endtask

    task automatic apply_step(input step_t s);
        if (s.drain) begin
            wait_idle();
        end
        acc_req_i       = s.req;
        acc_req_valid_i = 1'b1;
        case (s.req.op)
            OP_SRC: m_src = s.req.arga;
            OP_DST: m_dst = s.req.arga;
            OP_STR: begin
                m_str_src = s.req.arga;
                m_str_dst = s.req.argb;
            end
            OP_REP: m_reps = s.req.arga;
            default: ;
        endcase
        @(posedge clk_i);
        #2;
        acc_req_valid_i = 1'b0;
        rsp_allowed     = s.expect_rsp;
        if (s.expect_rsp) begin
            if (acc_rsp_valid_o !== 1'b1) begin
                $display("no response strobe for the command with tag %0d", s.req.tag);
                abort_run();
            end
            check_rsp(acc_rsp_o, s.rsp);
            if ((s.req.op == OP_CPY) && !s.rsp.error) begin
                push_bursts(s.req.arga, s.req.argb[1]);
                exp_next_id++;
            end
        end
        repeat (s.idle) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    // ----------------------------------------------------------
    // command table
    // ----------------------------------------------------------
    task automatic build_table();
        // after reset
        add_step(OP_STAT, 1, 32'h0, 32'h0, 1'b1, 32'd0, 1'b0, 1, 1'b0);
        add_step(OP_STAT, 2, 32'h0, 32'h1, 1'b1, 32'd0, 1'b0, 2, 1'b0);
        // single 1D copy
        add_step(OP_SRC, 0, 32'h1000_0000, 32'h0, 1'b0, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_DST, 0, 32'h2000_0000, 32'h0, 1'b0, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_CPY, 3, 32'd64, 32'h0, 1'b1, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_STAT, 4, 32'h0, 32'h2, 1'b1, 32'd1, 1'b0, 1, 1'b0);
        add_step(OP_STAT, 5, 32'h0, 32'h0, 1'b1, 32'd1, 1'b0, 1, 1'b1);
        // 2D copy, four rows
        add_step(OP_SRC, 0, 32'h1000_0100, 32'h0, 1'b0, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_DST, 0, 32'h2000_0800, 32'h0, 1'b0, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_STR, 0, 32'h40, 32'h100, 1'b0, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_REP, 0, 32'd4, 32'h0, 1'b0, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_CPY, 6, 32'd32, 32'h2, 1'b1, 32'd1, 1'b0, 0, 1'b0);
        add_step(OP_STAT, 7, 32'h0, 32'h2, 1'b1, 32'd1, 1'b0, 1, 1'b0);
        add_step(OP_STAT, 8, 32'h0, 32'h2, 1'b1, 32'd0, 1'b0, 0, 1'b1);
        add_step(OP_STAT, 9, 32'h0, 32'h0, 1'b1, 32'd2, 1'b0, 1, 1'b0);
        // unused opcodes
        add_step(3'd6, 10, 32'h0, 32'h0, 1'b1, 32'd0, 1'b1, 0, 1'b0);
        add_step(3'd7, 11, 32'h0, 32'h0, 1'b1, 32'd0, 1'b1, 1, 1'b0);
        // fill the job queue, the sixth copy is refused
        add_step(OP_REP, 0, 32'd6, 32'h0, 1'b0, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_SRC, 0, 32'h3000_0000, 32'h0, 1'b0, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_CPY, 12, 32'd16, 32'h2, 1'b1, 32'd2, 1'b0, 0, 1'b0);
        add_step(OP_CPY, 13, 32'd16, 32'h2, 1'b1, 32'd3, 1'b0, 0, 1'b0);
        add_step(OP_CPY, 14, 32'd16, 32'h2, 1'b1, 32'd4, 1'b0, 0, 1'b0);
        add_step(OP_CPY, 15, 32'd16, 32'h2, 1'b1, 32'd5, 1'b0, 0, 1'b0);
        add_step(OP_CPY, 16, 32'd16, 32'h2, 1'b1, 32'd6, 1'b0, 0, 1'b0);
        add_step(OP_CPY, 17, 32'd16, 32'h2, 1'b1, 32'd0, 1'b1, 0, 1'b0);
        add_step(OP_STAT, 18, 32'h0, 32'h3, 1'b1, 32'd1, 1'b0, 0, 1'b0);
        add_step(OP_STAT, 19, 32'h0, 32'h1, 1'b1, 32'd7, 1'b0, 1, 1'b0);
        add_step(OP_STAT, 20, 32'h0, 32'h0, 1'b1, 32'd7, 1'b0, 0, 1'b1);
        add_step(OP_STAT, 21, 32'h0, 32'h1, 1'b1, 32'd7, 1'b0, 0, 1'b0);
        add_step(OP_STAT, 22, 32'h0, 32'h2, 1'b1, 32'd0, 1'b0, 1, 1'b0);
        // 1D flag wins over the repetition count
        add_step(OP_CPY, 23, 32'd8, 32'h0, 1'b1, 32'd7, 1'b0, 1, 1'b0);
        add_step(OP_STAT, 24, 32'h0, 32'h0, 1'b1, 32'd8, 1'b0, 1, 1'b1);
        // one repetition gives a single burst
        add_step(OP_REP, 0, 32'd1, 32'h0, 1'b0, 32'd0, 1'b0, 0, 1'b0);
        add_step(OP_CPY, 25, 32'd4, 32'h2, 1'b1, 32'd8, 1'b0, 1, 1'b0);
        add_step(OP_STAT, 26, 32'h0, 32'h0, 1'b1, 32'd9, 1'b0, 0, 1'b1);
        add_step(OP_STAT, 27, 32'h0, 32'h1, 1'b1, 32'd9, 1'b0, 1, 1'b0);
    endtask

    // ----------------------------------------------------------
    // burst engine, completions in issue order
    // ----------------------------------------------------------
    initial begin
        forever begin
            @(posedge clk_i);
            #2;
            cycle++;
            // completion strobed last cycle was taken at this edge
            if (done_last_pending) begin
                exp_completed++;
            end
            done_last_pending = 1'b0;
            burst_done_i      = 1'b0;
            if ((done_ready.size() > 0) && (done_ready[0] <= cycle)) begin
                burst_done_i      = 1'b1;
                done_last_pending = done_last.pop_front();
                void'(done_ready.pop_front());
            end
        end
    end

    // sampled mid-cycle where all outputs are settled
    initial begin
        int unsigned delay;
        int unsigned ready;
        @(posedge rst_n_i);
        forever begin
            @(negedge clk_i);
            check_busy(busy_o, exp_next_id != exp_completed);
            if ((acc_rsp_valid_o !== 1'b0) && !rsp_allowed) begin
                $display("response strobe seen where no command asked for one");
                abort_run();
            end
            rsp_allowed = 1'b0;
            if (burst_valid_o !== 1'b0) begin
                if (exp_bursts.size() == 0) begin
                    $display("burst issued while no burst was expected");
                    abort_run();
                end
                check_burst(burst_o, exp_bursts[0]);
                delay = 1 + ($unsigned($random(seed)) % 6);
                ready = cycle + delay;
                if (ready <= last_ready) begin
                    ready = last_ready + 1;
                end
                last_ready = ready;
                done_ready.push_back(ready);
                done_last.push_back(exp_bursts[0].last);
                void'(exp_bursts.pop_front());
            end
        end
    end

    initial begin
        #1;
        repeat (steps.size() * 64) @(posedge clk_i);
        $display("timeout, the DMA did not finish the command table in time");
        abort_run();
    end

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        rst_n_i         = 1'b0;
        acc_req_valid_i = 1'b0;
        acc_req_i       = '0;
        burst_done_i    = 1'b0;
        build_table();
        repeat (16) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        repeat (2) begin
            @(posedge clk_i);
            #2;
        end
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        wait_idle();
        repeat (4) @(posedge clk_i);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* build.f */
+incdir+design
design/dma_cmd_pkg.sv
design/dma_xfer_pkg.sv
design/dma_fifo.sv
design/dma_cmd_decoder.sv
design/dma_twod_splitter.sv
design/dma_burst_tracker.sv
design/dma_tc_top.sv
tests/dma_tc_tb.sv
